//--- include/rsCore_cfg.svh
`ifndef RS_CORE_CFG_SVH
`define RS_CORE_CFG_SVH

// architectural register file
`define RS_NUM_REGS 32
`define RS_DATA_W 32

// producer tags, 0 means the value is present
`define RS_TAG_W 4

// station entry counts
`define RS_ADD_SLOTS 3
`define RS_MUL_SLOTS 2

// first tag of each bank, tags run upward from here
`define RS_ADD_BASE 1
`define RS_MUL_BASE 4

`endif

//--- design/rsEntryPkg.sv
`include "rsCore_cfg.svh"

package rsEntryPkg;

    typedef logic [`RS_TAG_W-1:0] tagT;

    typedef logic [$clog2(`RS_NUM_REGS)-1:0] regIdxT;

    typedef logic [`RS_DATA_W-1:0] dataT;

    // value is only meaningful once tag is zero
    typedef struct packed {
        dataT value;
        tagT  tag;
    } operandT;

    // slot tag is implied by position in the bank
    typedef struct packed {
        logic    busy;
        logic    fired;
        operandT j;
        operandT k;
    } entryT;

endpackage

//--- design/rsBusPkg.sv
package rsBusPkg;

    typedef enum logic {
        opAdd = 1'b0,
        opMul = 1'b1
    } opKindT;

    // held by the decoder while stall is high
    typedef struct packed {
        logic              valid;
        opKindT            opKind;
        rsEntryPkg::regIdxT rs;
        rsEntryPkg::regIdxT rt;
        rsEntryPkg::regIdxT rd;
        logic              useImm;
        rsEntryPkg::dataT  imm;
    } issueReqT;

    typedef struct packed {
        logic            valid;
        rsEntryPkg::tagT tag;
        rsEntryPkg::dataT data;
    } cdbT;

    // one per station entry, start is a single-cycle pulse
    typedef struct packed {
        logic             start;
        rsEntryPkg::dataT srcA;
        rsEntryPkg::dataT srcB;
        rsEntryPkg::tagT  tag;
    } unitStartT;

    typedef struct packed {
        logic               valid;
        rsEntryPkg::regIdxT addr;
        rsEntryPkg::dataT   data;
    } regWriteT;

endpackage

//--- design/registerStatus.sv
`timescale 1ns/1ps
`include "rsCore_cfg.svh"

module registerStatus (
    input  logic                clk,
    input  logic                reset,
    input  rsEntryPkg::regIdxT  rs,
    input  rsEntryPkg::regIdxT  rt,
    input  rsEntryPkg::regIdxT  rd,
    input  logic                issueAccept,
    input  rsEntryPkg::tagT     issueTag,
    input  rsEntryPkg::dataT    readData1,
    input  rsEntryPkg::dataT    readData2,
    input  rsBusPkg::cdbT       cdb,
    output rsEntryPkg::operandT opJ,
    output rsEntryPkg::operandT opK,
    output rsBusPkg::regWriteT  regWrite
);
    import rsEntryPkg::*;

    tagT    statTable [`RS_NUM_REGS];

    logic   cdbHit;
    regIdxT cdbIdx;

    logic   wrValid;
    regIdxT wrAddr;
    dataT   wrData;

    // tag 0 reads the file, a producer on the CDB this cycle is bypassed
    function automatic operandT lookup(regIdxT idx, tagT stat, dataT rfData);
        operandT op;
        op.tag   = '0;
        op.value = rfData;
        if (stat == '0) begin
            // last cycle's result may not have reached the file yet
            if (wrValid && wrAddr == idx) begin
                op.value = wrData;
            end
        end else if (cdb.valid && cdb.tag == stat) begin
            op.value = cdb.data;
        end else begin
            op.tag = stat;
        end
        return op;
    endfunction

    always_comb begin
        opJ = lookup(rs, statTable[rs], readData1);
        opK = lookup(rt, statTable[rt], readData2);
    end

    // at most one register can still point at a given tag
    always_comb begin
        cdbHit = 1'b0;
        cdbIdx = '0;
        for (int i = 0; i < `RS_NUM_REGS; i++) begin
            if (cdb.valid && cdb.tag != '0 && statTable[i] == cdb.tag) begin
                cdbHit = 1'b1;
                cdbIdx = regIdxT'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `RS_NUM_REGS; i++) begin
                statTable[i] <= '0;
            end
            wrValid <= 1'b0;
        end else begin
            wrValid <= cdbHit;
            if (cdbHit) begin
                statTable[cdbIdx] <= '0;
            end
            // a fresh rename overrides the clear
            if (issueAccept) begin
                statTable[rd] <= issueTag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cdbHit) begin
            wrAddr <= cdbIdx;
            wrData <= cdb.data;
        end
    end

    assign regWrite = '{valid: wrValid, addr: wrAddr, data: wrData};

endmodule

//--- design/operandCapture.sv
`timescale 1ns/1ps

module operandCapture (
    input  rsBusPkg::issueReqT  issueReq,
    input  rsEntryPkg::operandT opJ,
    input  rsEntryPkg::operandT opK,
    input  logic                addFull,
    input  logic                mulFull,
    output logic                stall,
    output logic                addAlloc,
    output logic                mulAlloc,
    output rsEntryPkg::entryT   entryIn
);
    import rsBusPkg::*;

    logic wantAdd;
    logic wantMul;
    logic immOperand;

    assign wantAdd = issueReq.valid && issueReq.opKind == opAdd;
    assign wantMul = issueReq.valid && issueReq.opKind == opMul;

    // only adds take an immediate
    assign immOperand = issueReq.useImm && issueReq.opKind == opAdd;

    // back-pressure when the requested bank has no free entry
    assign stall = (wantAdd && addFull) || (wantMul && mulFull);

    assign addAlloc = wantAdd && !addFull;
    assign mulAlloc = wantMul && !mulFull;

    always_comb begin
        entryIn.busy  = 1'b1;
        entryIn.fired = 1'b0;
        entryIn.j     = opJ;
        entryIn.k     = opK;
        if (immOperand) begin
            // immediate is always present, no producer
            entryIn.k.value = issueReq.imm;
            entryIn.k.tag   = '0;
        end
    end

endmodule

//--- design/stationBank.sv
`timescale 1ns/1ps

module stationBank #(
    parameter int SLOTS    = 3,
    parameter int BASE_TAG = 1
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                alloc,
    input  rsEntryPkg::entryT   entryIn,
    input  rsBusPkg::cdbT       cdb,
    output logic                full,
    output rsEntryPkg::tagT     allocTag,
    output rsBusPkg::unitStartT unitStart [SLOTS]
);
    import rsEntryPkg::*;
    import rsBusPkg::*;

    localparam int IDX_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;

    entryT            slots [SLOTS];
    logic [SLOTS-1:0] busyVec;
    logic [SLOTS-1:0] readyVec;
    logic [IDX_W-1:0] freeIdx;

    function automatic tagT tagOf(int idx);
        return tagT'(BASE_TAG + idx);
    endfunction

    // capture a broadcast value for an operand still waiting on it
    function automatic operandT wake(operandT op, cdbT bus);
        operandT res;
        res = op;
        if (bus.valid && op.tag != '0 && op.tag == bus.tag) begin
            res.value = bus.data;
            res.tag   = '0;
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < SLOTS; i++) begin
            busyVec[i]  = slots[i].busy;
            readyVec[i] = slots[i].busy && !slots[i].fired &&
                          slots[i].j.tag == '0 && slots[i].k.tag == '0;
        end
    end

    // lowest free slot wins
    always_comb begin
        freeIdx = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (!busyVec[i]) begin
                freeIdx = IDX_W'(i);
            end
        end
    end

    assign full     = &busyVec;
    assign allocTag = tagOf(int'(freeIdx));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < SLOTS; i++) begin
                slots[i]     <= '0;
                unitStart[i] <= '0;
            end
        end else begin
            for (int i = 0; i < SLOTS; i++) begin
                unitStart[i].start <= 1'b0;
                if (alloc && int'(freeIdx) == i) begin
                    slots[i] <= entryIn;
                end else if (busyVec[i]) begin
                    if (cdb.valid && cdb.tag == tagOf(i)) begin
                        // own result is out, entry can be reused
                        slots[i].busy  <= 1'b0;
                        slots[i].fired <= 1'b0;
                    end else if (readyVec[i]) begin
                        slots[i].fired     <= 1'b1;
                        unitStart[i].start <= 1'b1;
                        unitStart[i].srcA  <= slots[i].j.value;
                        unitStart[i].srcB  <= slots[i].k.value;
                        unitStart[i].tag   <= tagOf(i);
                    end else begin
                        slots[i].j <= wake(slots[i].j, cdb);
                        slots[i].k <= wake(slots[i].k, cdb);
                    end
                end
            end
        end
    end

endmodule

//--- design/reservationStation.sv
`timescale 1ns/1ps
`include "rsCore_cfg.svh"

module reservationStation (
    input  logic                clk,
    input  logic                reset,
    input  rsBusPkg::issueReqT  issueReq,
    input  rsEntryPkg::dataT    readData1,
    input  rsEntryPkg::dataT    readData2,
    input  rsBusPkg::cdbT       cdb,
    output rsEntryPkg::regIdxT  readAddr1,
    output rsEntryPkg::regIdxT  readAddr2,
    output rsBusPkg::unitStartT addStart [`RS_ADD_SLOTS],
    output rsBusPkg::unitStartT mulStart [`RS_MUL_SLOTS],
    output rsBusPkg::regWriteT  regWrite,
    output logic                stall
);
    import rsEntryPkg::*;

    operandT opJ;
    operandT opK;
    entryT   entryIn;

    logic    addAlloc;
    logic    mulAlloc;
    logic    addFull;
    logic    mulFull;
    tagT     addTag;
    tagT     mulTag;

    logic    issueAccept;
    tagT     issueTag;

    // register file is read combinationally in the issue cycle
    assign readAddr1 = issueReq.rs;
    assign readAddr2 = issueReq.rt;

    assign issueAccept = addAlloc | mulAlloc;
    assign issueTag    = addAlloc ? addTag : mulTag;

    registerStatus u_registerStatus (
        .clk         (clk),
        .reset       (reset),
        .rs          (issueReq.rs),
        .rt          (issueReq.rt),
        .rd          (issueReq.rd),
        .issueAccept (issueAccept),
        .issueTag    (issueTag),
        .readData1   (readData1),
        .readData2   (readData2),
        .cdb         (cdb),
        .opJ         (opJ),
        .opK         (opK),
        .regWrite    (regWrite)
    );

    operandCapture u_operandCapture (
        .issueReq (issueReq),
        .opJ      (opJ),
        .opK      (opK),
        .addFull  (addFull),
        .mulFull  (mulFull),
        .stall    (stall),
        .addAlloc (addAlloc),
        .mulAlloc (mulAlloc),
        .entryIn  (entryIn)
    );

    stationBank #(
        .SLOTS    (`RS_ADD_SLOTS),
        .BASE_TAG (`RS_ADD_BASE)
    ) u_addBank (
        .clk       (clk),
        .reset     (reset),
        .alloc     (addAlloc),
        .entryIn   (entryIn),
        .cdb       (cdb),
        .full      (addFull),
        .allocTag  (addTag),
        .unitStart (addStart)
    );

    stationBank #(
        .SLOTS    (`RS_MUL_SLOTS),
        .BASE_TAG (`RS_MUL_BASE)
    ) u_mulBank (
        .clk       (clk),
        .reset     (reset),
        .alloc     (mulAlloc),
        .entryIn   (entryIn),
        .cdb       (cdb),
        .full      (mulFull),
        .allocTag  (mulTag),
        .unitStart (mulStart)
    );

endmodule

//--- tb/rsCoreTb.sv
`timescale 1ns/1ps
`include "rsCore_cfg.svh"

module rsCoreTb;
    import rsEntryPkg::*;
    import rsBusPkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int SAMPLE_DELAY = 18;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 10;
    localparam int NUM_ROWS     = 9;

    localparam int BANK_NONE = 0;
    localparam int BANK_ADD  = 1;
    localparam int BANK_MUL  = 2;

    localparam dataT MUL_RESULT = 32'h0000_ABCD;
    localparam dataT ADD_RESULT = 32'h0000_5A5A;

    // one step of stimulus with what the DUT should answer
    typedef struct packed {
        logic [3:0] behavior;
        issueReqT   req;
        cdbT        bus;
        logic       expStall;
        logic [1:0] expBank;
        logic [1:0] expSlot;
        logic [3:0] expWait;
        dataT       expSrcA;
        dataT       expSrcB;
        tagT        expTag;
        logic       expWrValid;
        regIdxT     expWrAddr;
        dataT       expWrData;
    } stepRowT;

    logic      clk;
    logic      reset;
    issueReqT  issueReq;
    cdbT       cdb;
    dataT      readData1;
    dataT      readData2;
    regIdxT    readAddr1;
    regIdxT    readAddr2;
    unitStartT addStart [`RS_ADD_SLOTS];
    unitStartT mulStart [`RS_MUL_SLOTS];
    regWriteT  regWrite;
    logic      stall;

    dataT      regFile [`RS_NUM_REGS];
    stepRowT   rows [NUM_ROWS];
    int        errCount = 0;
    int        checkCount = 0;

    reservationStation u_reservationStation (
        .clk       (clk),
        .reset     (reset),
        .issueReq  (issueReq),
        .readData1 (readData1),
        .readData2 (readData2),
        .cdb       (cdb),
        .readAddr1 (readAddr1),
        .readAddr2 (readAddr2),
        .addStart  (addStart),
        .mulStart  (mulStart),
        .regWrite  (regWrite),
        .stall     (stall)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic dataT regInit(int idx);
        return dataT'(idx * 16);
    endfunction

    // combinational register file written one cycle after the CDB
    initial begin
        for (int i = 0; i < `RS_NUM_REGS; i++) begin
            regFile[i] = regInit(i);
        end
    end

    always @(posedge clk) begin
        if (regWrite.valid) begin
            regFile[regWrite.addr] <= regWrite.data;
        end
    end

    assign readData1 = regFile[readAddr1];
    assign readData2 = regFile[readAddr2];

    function automatic tagT addTag(int slot);
        return tagT'(`RS_ADD_BASE + slot);
    endfunction

    function automatic tagT mulTag(int slot);
        return tagT'(`RS_MUL_BASE + slot);
    endfunction

    function automatic issueReqT request(opKindT kind, int rs, int rt, int rd,
                                         logic useImm, dataT imm);
        issueReqT req;
        req.valid  = 1'b1;
        req.opKind = kind;
        req.rs     = regIdxT'(rs);
        req.rt     = regIdxT'(rt);
        req.rd     = regIdxT'(rd);
        req.useImm = useImm;
        req.imm    = imm;
        return req;
    endfunction

    function automatic cdbT broadcast(tagT tag, dataT data);
        cdbT bus;
        bus.valid = 1'b1;
        bus.tag   = tag;
        bus.data  = data;
        return bus;
    endfunction

    function automatic stepRowT makeRow(int beh, issueReqT req, cdbT bus, logic expStall,
                                        int bank, int slot, dataT srcA, dataT srcB, tagT tag);
        stepRowT row;
        row            = '0;
        row.behavior   = 4'(beh);
        row.req        = req;
        row.bus        = bus;
        row.expStall   = expStall;
        row.expBank    = 2'(bank);
        row.expSlot    = 2'(slot);
        // start follows the row's first edge by one more edge
        row.expWait    = 4'd1;
        row.expSrcA    = srcA;
        row.expSrcB    = srcB;
        row.expTag     = tag;
        return row;
    endfunction

    task automatic expectWrite(int r, int addr, dataT data);
        rows[r].expWrValid = 1'b1;
        rows[r].expWrAddr  = regIdxT'(addr);
        rows[r].expWrData  = data;
    endtask

    task automatic expectDelay(int r, int cycles);
        rows[r].expWait = 4'(cycles);
    endtask

    task automatic fillTable();
        rows[0] = makeRow(1, '0, '0, 1'b0, BANK_NONE, 0, '0, '0, '0);
        rows[1] = makeRow(2, request(opAdd, 2, 3, 10, 1'b0, '0), '0, 1'b0,
                          BANK_ADD, 0, regInit(2), regInit(3), addTag(0));
        rows[2] = makeRow(3, request(opAdd, 4, 9, 11, 1'b1, 32'h1234), '0, 1'b0,
                          BANK_ADD, 1, regInit(4), 32'h1234, addTag(1));
        // mul renames r5 so the add after it must wait
        rows[3] = makeRow(4, request(opMul, 6, 7, 5, 1'b0, '0), '0, 1'b0,
                          BANK_MUL, 0, regInit(6), regInit(7), mulTag(0));
        rows[4] = makeRow(4, request(opAdd, 5, 1, 12, 1'b0, '0), '0, 1'b0,
                          BANK_NONE, 0, '0, '0, '0);
        rows[5] = makeRow(4, '0, broadcast(mulTag(0), MUL_RESULT), 1'b0,
                          BANK_ADD, 2, MUL_RESULT, regInit(1), addTag(2));
        expectWrite(5, 5, MUL_RESULT);
        // all add entries taken so the fourth add is held
        rows[6] = makeRow(5, request(opAdd, 6, 7, 13, 1'b0, '0), '0, 1'b1,
                          BANK_NONE, 0, '0, '0, '0);
        rows[7] = makeRow(5, request(opAdd, 6, 7, 13, 1'b0, '0),
                          broadcast(addTag(0), ADD_RESULT), 1'b1,
                          BANK_ADD, 0, regInit(6), regInit(7), addTag(0));
        expectWrite(7, 10, ADD_RESULT);
        // stall drops right after the release, then one edge to accept
        expectDelay(7, 2);
        rows[8] = makeRow(5, '0, '0, 1'b0, BANK_NONE, 0, '0, '0, '0);
    endtask

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
        checkCount++;
        assert (got === exp) else begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errCount++;
        end
    endtask

    function automatic unitStartT startOf(int bank, int slot);
        unitStartT st;
        if (bank == BANK_MUL) begin
            st = mulStart[slot];
        end else begin
            st = addStart[slot];
        end
        return st;
    endfunction

    function automatic logic anyStart();
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < `RS_ADD_SLOTS; i++) begin
            seen = seen | addStart[i].start;
        end
        for (int i = 0; i < `RS_MUL_SLOTS; i++) begin
            seen = seen | mulStart[i].start;
        end
        return seen;
    endfunction

    // one decoder clock entered and left just after an edge
    task automatic stepCycle(output logic stallSeen);
        logic taken;
        #SAMPLE_DELAY;
        stallSeen = stall;
        taken = issueReq.valid && !stall;
        @(posedge clk);
        #DRIVE_DELAY;
        if (taken) begin
            issueReq.valid = 1'b0;
        end
        cdb.valid = 1'b0;
    endtask

    task automatic runRow(int r);
        stepRowT   row;
        unitStartT st;
        string     unitName;
        logic      stallSeen;
        logic      ignored;
        logic      found;
        int        waited;
        int        errBefore;
        row       = rows[r];
        errBefore = errCount;
        unitName  = (row.expBank == BANK_MUL) ? "mulStart" : "addStart";
        issueReq  = row.req;
        cdb       = row.bus;
        stepCycle(stallSeen);
        checkValue("stall", stallSeen, row.expStall);
        checkValue("regWrite.valid", regWrite.valid, row.expWrValid);
        if (row.expWrValid) begin
            checkValue("regWrite.addr", regWrite.addr, row.expWrAddr);
            checkValue("regWrite.data", regWrite.data, row.expWrData);
        end
        if (row.expBank == BANK_NONE) begin
            checkValue("start (any unit)", anyStart(), 1'b0);
            stepCycle(ignored);
            checkValue("start (any unit)", anyStart(), 1'b0);
        end else begin
            st     = startOf(row.expBank, row.expSlot);
            found  = st.start;
            waited = 0;
            while (!found && waited < WAIT_LIMIT) begin
                stepCycle(ignored);
                waited++;
                st    = startOf(row.expBank, row.expSlot);
                found = st.start;
            end
            assert (found) else begin
                $display("timeout: %s slot %0d never started within %0d cycles",
                         unitName, row.expSlot, WAIT_LIMIT);
                errCount++;
            end
            if (found) begin
                checkCount++;
                assert (waited == int'(row.expWait)) else begin
                    $display("%s slot %0d started after %0d extra cycles, expected %0d",
                             unitName, row.expSlot, waited, row.expWait);
                    errCount++;
                end
                checkValue($sformatf("%s[%0d].srcA", unitName, row.expSlot),
                           st.srcA, row.expSrcA);
                checkValue($sformatf("%s[%0d].srcB", unitName, row.expSlot),
                           st.srcB, row.expSrcB);
                checkValue($sformatf("%s[%0d].tag", unitName, row.expSlot),
                           st.tag, row.expTag);
                // pulse is one cycle wide
                stepCycle(ignored);
                st = startOf(row.expBank, row.expSlot);
                checkValue($sformatf("%s[%0d].start", unitName, row.expSlot),
                           st.start, 1'b0);
            end
        end
        if (errCount == errBefore) begin
            $display("row %0d (behavior %0d): ok", r, row.behavior);
        end else begin
            $display("row %0d (behavior %0d): %0d error(s)", r, row.behavior,
                     errCount - errBefore);
        end
    endtask

    initial begin
        issueReq = '0;
        cdb      = '0;
        reset    = 1'b1;
        fillTable();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            runRow(r);
        end
        $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checkCount, errCount);
        if (errCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- rsCore.f
+incdir+include
design/rsEntryPkg.sv
design/rsBusPkg.sv
design/registerStatus.sv
design/operandCapture.sv
design/stationBank.sv
design/reservationStation.sv
tb/rsCoreTb.sv
